// File: logic/cache_pkg.sv
`default_nettype none

package cache_pkg;

	// ==================================================
	// geometry
	// ==================================================
	parameter int WAYS        = 4;
	parameter int LINE_BYTES  = 16;
	parameter int SETS        = 64;		// default, top level may override
	parameter int OFFSET_BITS = 4;
	parameter int INDEX_BITS  = 6;
	parameter int TAG_BITS    = 22;

	typedef logic [31:0]               addr_t;
	typedef logic [TAG_BITS-1:0]       tag_t;
	typedef logic [INDEX_BITS-1:0]     index_t;
	typedef logic [LINE_BYTES*8-1:0]   line_data_t;
	typedef logic [LINE_BYTES-1:0]     byte_sel_t;
	typedef logic [7:0]                tid_t;
	typedef logic [WAYS-1:0]           way_mask_t;

	typedef enum logic {WR_STORE, WR_INVAL} wr_op_e;

	typedef enum logic [1:0] {RD_IDLE, RD_LOOK, RD_DECIDE, RD_WAIT} rd_state_e;

	// ==================================================
	// line and request types
	// ==================================================
	typedef struct packed {
		tag_t       tag;
		logic       modified;
		line_data_t dat;
	} cache_way_t;

	typedef struct packed {
		cache_way_t [WAYS-1:0] w;		// w[0] is the newest line
	} line_set_t;

	typedef struct packed {logic valid; addr_t adr; tid_t tid;} rd_req_t;
	typedef struct packed {logic ack; tid_t tid; line_data_t dat;} rd_resp_t;
	typedef struct packed {logic valid; addr_t adr; tid_t tid;} miss_req_t;
	typedef struct packed {logic valid; addr_t adr; line_data_t dat;} ld_req_t;

	typedef struct packed {
		logic       valid;
		wr_op_e     op;
		addr_t      adr;
		byte_sel_t  sel;
		line_data_t dat;
	} wr_req_t;

	function automatic index_t adr_index(addr_t adr);
		return adr[OFFSET_BITS +: INDEX_BITS];
	endfunction

	function automatic tag_t adr_tag(addr_t adr);
		return adr[31 -: TAG_BITS];
	endfunction

endpackage

`default_nettype wire

// File: logic/set_ram.sv
`timescale 1ns/1ps
`default_nettype none

module set_ram import cache_pkg::*; #(
	parameter int SETS = cache_pkg::SETS
) (
	input  wire logic      wclk,
	input  wire logic      we,
	input  wire index_t    waddr,
	input  wire line_set_t wdata,
	input  wire logic      re,
	input  wire index_t    raddr,
	output line_set_t      rdata
);

	localparam int AW = $clog2(SETS);

	line_set_t mem [0:SETS-1];

	// single write port
	always_ff @(posedge wclk) begin
		if (we)
			mem[waddr[AW-1:0]] <= wdata;
	end

	// registered read, holds while re is low
	always_ff @(posedge wclk) begin
		if (re)
			rdata <= mem[raddr[AW-1:0]];
	end

endmodule

`default_nettype wire

// File: logic/valid_bits.sv
`timescale 1ns/1ps
`default_nettype none

module valid_bits import cache_pkg::*; #(
	parameter int SETS = cache_pkg::SETS
) (
	input  wire logic      wclk,
	input  wire logic      rst1,
	input  wire index_t    rd_index,
	input  wire index_t    wr_index,
	output way_mask_t      rd_valid,
	output way_mask_t      wr_valid,
	input  wire logic      load_shift,
	input  wire logic      set_way,
	input  wire logic      clr_way,
	input  wire way_mask_t way_sel,
	input  wire index_t    upd_index
);

	localparam int AW = $clog2(SETS);

	way_mask_t vb [0:SETS-1];
	way_mask_t cur;

	assign rd_valid = vb[rd_index[AW-1:0]];
	assign wr_valid = vb[wr_index[AW-1:0]];
	assign cur      = vb[upd_index[AW-1:0]];

	// ==================================================
	// flag update
	// ==================================================
	always_ff @(posedge wclk) begin
		if (rst1) begin
			for (int s = 0; s < SETS; s++)
				vb[s] <= '0;
		end
		else begin
			if (load_shift)
				vb[upd_index[AW-1:0]] <= {cur[WAYS-2:0], 1'b1};	// new line in way 0
			else if (set_way)
				vb[upd_index[AW-1:0]] <= cur | way_sel;
			else if (clr_way)
				vb[upd_index[AW-1:0]] <= cur & ~way_sel;
		end
	end

	// the load and write paths never update in the same cycle
	a_no_overlap: assert property (@(posedge wclk) disable iff (rst1)
		load_shift |-> !(set_way || clr_way));

endmodule

`default_nettype wire

// File: logic/tag_match.sv
`timescale 1ns/1ps
`default_nettype none

module tag_match import cache_pkg::*; (
	input  wire logic      wclk,
	input  wire logic      rst1,
	input  wire logic      lookup,
	input  wire tag_t      tag,
	input  wire line_set_t ways,
	input  wire way_mask_t valid,
	output way_mask_t      hit,
	output line_data_t     hit_data
);

	way_mask_t match;

	always_comb begin
		for (int w = 0; w < WAYS; w++)
			match[w] = (ways.w[w].tag == tag) && valid[w];
	end

	always_ff @(posedge wclk) begin
		if (rst1)
			hit <= '0;
		else if (lookup)
			hit <= match;
		else
			hit <= '0;		// only one cycle valid
	end

	// data of the hit way, zero when nothing hit
	always_comb begin
		hit_data = '0;
		for (int w = 0; w < WAYS; w++) begin
			if (hit[w])
				hit_data = ways.w[w].dat;
		end
	end

	// a line is never resident twice in one set
	a_onehot: assert property (@(posedge wclk) disable iff (rst1) $onehot0(hit));

endmodule

`default_nettype wire

// File: logic/read_port.sv
`timescale 1ns/1ps
`default_nettype none

module read_port import cache_pkg::*; (
	input  wire logic       wclk,
	input  wire logic       rst1,
	input  wire rd_req_t    rd_req,
	output logic            rd_ready,
	output logic            ram_re,
	output index_t          ram_index,
	output tag_t            look_tag,
	output logic            lookup,
	input  wire way_mask_t  hit,
	input  wire line_data_t hit_data,
	input  wire logic       load_done,
	output rd_resp_t        rd_resp,
	output miss_req_t       miss
);

	rd_state_e  state;
	addr_t      adr_q;
	tid_t       tid_q;
	logic       look_ph;		// second cycle of a lookup
	logic       hit_q;
	line_data_t dat_q;
	logic       missed;			// miss already reported for this request

	assign rd_ready  = (state == RD_IDLE);
	assign ram_re    = (state == RD_IDLE) ? rd_req.valid : (state == RD_WAIT) && load_done;
	assign ram_index = (state == RD_IDLE) ? adr_index(rd_req.adr) : adr_index(adr_q);
	assign look_tag  = adr_tag(adr_q);
	assign lookup    = (state == RD_LOOK) && !look_ph;

	always_ff @(posedge wclk) begin
		if (rst1) begin
			state         <= RD_IDLE;
			look_ph       <= 1'b0;
			hit_q         <= 1'b0;
			missed        <= 1'b0;
			rd_resp.ack   <= 1'b0;
			miss.valid    <= 1'b0;
		end
		else begin
			miss.valid <= 1'b0;
			case (state)
			RD_IDLE:
				if (rd_req.valid) begin
					state  <= RD_LOOK;
					missed <= 1'b0;
				end
			RD_LOOK:
				if (look_ph) begin
					look_ph <= 1'b0;
					hit_q   <= |hit;
					state   <= RD_DECIDE;
				end
				else
					look_ph <= 1'b1;
			RD_DECIDE:
				if (rd_resp.ack) begin
					rd_resp.ack <= 1'b0;	// one cycle pulse
					state       <= RD_IDLE;
				end
				else if (hit_q)
					rd_resp.ack <= 1'b1;
				else begin
					miss.valid <= !missed;
					missed     <= 1'b1;
					state      <= RD_WAIT;
				end
			RD_WAIT:
				if (load_done)
					state <= RD_LOOK;	// retry with the fresh set
			default:
				state <= RD_IDLE;
			endcase
		end
	end

	// ==================================================
	// payload
	// ==================================================
	always_ff @(posedge wclk) begin
		if (state == RD_IDLE && rd_req.valid) begin
			adr_q <= rd_req.adr;
			tid_q <= rd_req.tid;
		end
		if (state == RD_LOOK && look_ph)
			dat_q <= hit_data;
	end

	assign rd_resp.tid = tid_q;
	assign rd_resp.dat = dat_q;
	assign miss.adr    = adr_q;
	assign miss.tid    = tid_q;

	a_no_idle_ack: assert property (@(posedge wclk) disable iff (rst1)
		rd_resp.ack |-> state != RD_IDLE);

endmodule

`default_nettype wire

// File: logic/line_update.sv
`timescale 1ns/1ps
`default_nettype none

module line_update import cache_pkg::*; (
	input  wire logic      wclk,
	input  wire logic      rst1,
	input  wire ld_req_t   ld_req,
	input  wire wr_req_t   wr_req,
	output logic           wr_ready,
	output logic           wr_ack,
	output logic           ram_re,
	output index_t         ram_index,
	input  wire line_set_t ram_set,
	output tag_t           look_tag,
	output logic           lookup,
	input  wire way_mask_t hit,
	output logic           ram_we,
	output index_t         ram_windex,
	output line_set_t      ram_wdata,
	output logic           load_shift,
	output logic           set_way,
	output logic           clr_way,
	output way_mask_t      way_sel,
	output logic           load_done
);

	logic      ld_p1, ld_p2;		// load pipeline stages
	addr_t     ld_adr_q;
	line_data_t ld_dat_q;
	line_set_t ld_set_q;

	logic      wr_p1, wr_p2;		// write lookup, write update pending
	logic      wr_held;
	wr_req_t   wr_q;
	line_set_t wr_set_q;
	way_mask_t hit_hold;
	way_mask_t cur_hit;
	line_set_t merged;
	logic      wr_acc, upd_go;

	assign wr_ready = !(wr_p1 || wr_p2 || ld_p1 || ld_p2 || ld_req.valid);
	assign wr_acc   = wr_req.valid && wr_ready;
	assign upd_go   = wr_p2 && !ld_p2;		// a load write takes the port first
	assign cur_hit  = wr_held ? hit_hold : hit;

	// RAM read for a load or a newly accepted write
	assign ram_re    = ld_req.valid || wr_acc;
	assign ram_index = ld_req.valid ? adr_index(ld_req.adr) : adr_index(wr_req.adr);
	assign look_tag  = adr_tag(wr_q.adr);
	assign lookup    = wr_p1;

	// ==================================================
	// byte merge / invalidate
	// ==================================================
	always_comb begin
		merged = wr_set_q;
		for (int w = 0; w < WAYS; w++) begin
			if (cur_hit[w]) begin
				if (wr_q.op == WR_STORE) begin
					for (int b = 0; b < LINE_BYTES; b++)
						if (wr_q.sel[b])
							merged.w[w].dat[b*8 +: 8] = wr_q.dat[b*8 +: 8];
					merged.w[w].modified = 1'b1;
				end
				else
					merged.w[w].modified = 1'b0;	// line dropped
			end
		end
	end

	assign ram_we     = ld_p2 || (upd_go && |cur_hit);
	assign ram_windex = ld_p2 ? adr_index(ld_adr_q) : adr_index(wr_q.adr);
	assign ram_wdata  = ld_p2 ? ld_set_q : merged;
	assign load_shift = ld_p2;
	assign set_way    = upd_go && |cur_hit && (wr_q.op == WR_STORE);
	assign clr_way    = upd_go && |cur_hit && (wr_q.op == WR_INVAL);
	assign way_sel    = cur_hit;

	always_ff @(posedge wclk) begin
		if (rst1) begin
			ld_p1     <= 1'b0;
			ld_p2     <= 1'b0;
			load_done <= 1'b0;
			wr_p1     <= 1'b0;
			wr_p2     <= 1'b0;
			wr_held   <= 1'b0;
			wr_ack    <= 1'b0;
		end
		else begin
			ld_p1     <= ld_req.valid;
			ld_p2     <= ld_p1;
			load_done <= ld_p2;
			wr_p1     <= wr_acc;
			wr_ack    <= upd_go;		// write through, hit or not
			if (wr_p1)
				wr_p2 <= 1'b1;
			else if (upd_go)
				wr_p2 <= 1'b0;
			wr_held <= wr_p2 && ld_p2;
		end
	end

	// payload registers
	always_ff @(posedge wclk) begin
		if (ld_req.valid) begin
			ld_adr_q <= ld_req.adr;
			ld_dat_q <= ld_req.dat;
		end
		if (ld_p1) begin
			ld_set_q.w[0] <= '{tag: adr_tag(ld_adr_q), modified: 1'b0, dat: ld_dat_q};
			for (int w = 1; w < WAYS; w++)
				ld_set_q.w[w] <= ram_set.w[w-1];	// way 3 falls out
		end
		if (wr_acc)
			wr_q <= wr_req;
		if (wr_p1)
			wr_set_q <= ram_set;
		if (wr_p2 && !wr_held)
			hit_hold <= hit;
	end

	// the load source spaces its requests
	a_ld_spacing: assert property (@(posedge wclk) disable iff (rst1)
		ld_req.valid |=> !ld_req.valid [*3]);

endmodule

`default_nettype wire

// File: logic/mpmc_cache.sv
`timescale 1ns/1ps
`default_nettype none

module mpmc_cache import cache_pkg::*; #(
	parameter int SETS = cache_pkg::SETS
) (
	input  wire logic    wclk,
	input  wire logic    rst1,
	input  wire rd_req_t rd_req,
	output logic         rd_ready,
	output rd_resp_t     rd_resp,
	output miss_req_t    miss,
	input  wire ld_req_t ld_req,
	input  wire wr_req_t wr_req,
	output logic         wr_ready,
	output logic         wr_ack
);

	// ==================================================
	// read side
	// ==================================================
	logic       rd_re, rd_lookup;
	index_t     rd_index;
	tag_t       rd_tag;
	line_set_t  rd_set;
	way_mask_t  rd_valid, rd_hit;
	line_data_t rd_hit_data;

	// ==================================================
	// write / load side
	// ==================================================
	logic       wr_re, wr_lookup, ram_we;
	index_t     wr_index, ram_windex;
	tag_t       wr_tag;
	line_set_t  wr_set, ram_wdata;
	way_mask_t  wr_valid, wr_hit, way_sel;
	logic       load_shift, set_way, clr_way, load_done;

	read_port u_read_port (
		.wclk, .rst1, .rd_req, .rd_ready,
		.ram_re(rd_re), .ram_index(rd_index),
		.look_tag(rd_tag), .lookup(rd_lookup),
		.hit(rd_hit), .hit_data(rd_hit_data),
		.load_done, .rd_resp, .miss
	);

	line_update u_line_update (
		.wclk, .rst1, .ld_req, .wr_req, .wr_ready, .wr_ack,
		.ram_re(wr_re), .ram_index(wr_index), .ram_set(wr_set),
		.look_tag(wr_tag), .lookup(wr_lookup), .hit(wr_hit),
		.ram_we, .ram_windex, .ram_wdata,
		.load_shift, .set_way, .clr_way, .way_sel, .load_done
	);

	// both copies take every write
	set_ram #(.SETS(SETS)) rd_ram (
		.wclk, .we(ram_we), .waddr(ram_windex), .wdata(ram_wdata),
		.re(rd_re), .raddr(rd_index), .rdata(rd_set)
	);

	set_ram #(.SETS(SETS)) wr_ram (
		.wclk, .we(ram_we), .waddr(ram_windex), .wdata(ram_wdata),
		.re(wr_re), .raddr(wr_index), .rdata(wr_set)
	);

	tag_match rd_match (
		.wclk, .rst1, .lookup(rd_lookup), .tag(rd_tag), .ways(rd_set),
		.valid(rd_valid), .hit(rd_hit), .hit_data(rd_hit_data)
	);

	tag_match wr_match (
		.wclk, .rst1, .lookup(wr_lookup), .tag(wr_tag), .ways(wr_set),
		.valid(wr_valid), .hit(wr_hit), .hit_data()
	);

	valid_bits #(.SETS(SETS)) u_valid_bits (
		.wclk, .rst1,
		.rd_index, .wr_index(ram_windex),
		.rd_valid, .wr_valid,
		.load_shift, .set_way, .clr_way, .way_sel,
		.upd_index(ram_windex)
	);

endmodule

`default_nettype wire

// File: verification/mpmc_cache_tb.sv
`timescale 1ns/1ps
`default_nettype none

module mpmc_cache_tb import cache_pkg::*; ;

	localparam int CLK_NS  = 40;
	localparam int RST_CYC = 16;
	localparam int N_OPS   = 64;		// upper bound on operations in the run

	logic      wclk;
	logic      rst1;
	rd_req_t   rd_req;
	logic      rd_ready;
	rd_resp_t  rd_resp;
	miss_req_t miss;
	ld_req_t   ld_req;
	wr_req_t   wr_req;
	logic      wr_ready;
	logic      wr_ack;

	// reference model, way 0 newest
	tag_t       m_tag [SETS][WAYS];
	line_data_t m_dat [SETS][WAYS];
	logic       m_vld [SETS][WAYS];

	logic [31:0] rng;
	logic        exp_hit;		// current read should hit
	logic        fill_ok;		// fill of the missed line is on its way
	addr_t       exp_adr;
	tid_t        exp_tid;
	line_data_t  exp_dat;
	int          rd_seq, miss_seq;
	int          errors, n_rd_ack, n_miss, n_wr_ack;
	int          sets_used [3] = '{5, 17, 42};

	mpmc_cache #(.SETS(SETS)) mpmc_cache_i (
		.wclk, .rst1, .rd_req, .rd_ready, .rd_resp, .miss,
		.ld_req, .wr_req, .wr_ready, .wr_ack
	);

	initial begin
		wclk = 1'b0;
		forever #(CLK_NS/2) wclk = ~wclk;
	end

	function automatic logic [31:0] next_rand();
		rng ^= rng << 13;
		rng ^= rng >> 17;
		rng ^= rng << 5;
		return rng;
	endfunction

	function automatic line_data_t rand_line();
		return {next_rand(), next_rand(), next_rand(), next_rand()};
	endfunction

	// address split: tag [31:10], set [9:4], byte offset [3:0]
	function automatic int find_way(input addr_t a);
		for (int w = 0; w < WAYS; w++)
			if (m_vld[a[9:4]][w] && m_tag[a[9:4]][w] == a[31:10])
				return w;
		return -1;
	endfunction

	function automatic addr_t new_adr(input int s);
		addr_t a;
		do
			a = {tag_t'(next_rand()), index_t'(s), 4'(next_rand())};
		while (find_way(a) >= 0);		// never load a resident line
		return a;
	endfunction

	function void log_error(input string msg);
		errors++;
		$display("ERROR %0t: %s", $time, msg);
	endfunction

	// ==================================================
	// checks
	// ==================================================
	a_reset_idle: assert property (@(posedge wclk) $fell(rst1) |->
		rd_ready && wr_ready && !rd_resp.ack && !miss.valid && !wr_ack)
		else log_error("outputs not idle after reset");

	a_hit_timing: assert property (@(posedge wclk) disable iff (rst1)
		rd_req.valid && rd_ready && exp_hit |=>
		!rd_resp.ack [*3] ##1 rd_resp.ack ##1 !rd_resp.ack)
		else log_error("read hit ack not a single pulse after edge 3");

	a_miss_timing: assert property (@(posedge wclk) disable iff (rst1)
		rd_req.valid && rd_ready && !exp_hit |=> !miss.valid [*3]
		##1 (miss.valid && miss.adr == exp_adr && miss.tid == exp_tid) ##1 !miss.valid)
		else log_error("miss report wrong in timing, adr or tid");

	a_miss_once: assert property (@(posedge wclk) disable iff (rst1)
		miss.valid |-> miss_seq != rd_seq)
		else log_error("second miss reported for one read");

	a_ack_data: assert property (@(posedge wclk) disable iff (rst1)
		rd_resp.ack |-> (exp_hit || fill_ok) && rd_resp.tid == exp_tid
		&& rd_resp.dat == exp_dat)
		else log_error("unexpected read ack or wrong tid/data");

	a_fill_ack: assert property (@(posedge wclk) disable iff (rst1)
		ld_req.valid && fill_ok |=> !rd_resp.ack [*6] ##1 rd_resp.ack)
		else log_error("no ack after the retry that follows the fill");

	a_wr_timing: assert property (@(posedge wclk) disable iff (rst1)
		wr_req.valid && wr_ready |=> !wr_ack [*2] ##1 wr_ack ##1 !wr_ack)
		else log_error("write ack not a single pulse after edge 2");

	always @(posedge wclk) begin
		if (miss.valid) begin
			miss_seq <= rd_seq;
			n_miss   <= n_miss + 1;
		end
		if (rd_resp.ack)
			n_rd_ack <= n_rd_ack + 1;
		if (wr_ack)
			n_wr_ack <= n_wr_ack + 1;
	end

	// ==================================================
	// stimulus tasks
	// ==================================================
	task automatic load_line(input addr_t adr, input line_data_t dat, input logic fill);
		int s;
		s = adr[9:4];
		@(posedge wclk);
		ld_req  <= '{valid: 1'b1, adr: adr, dat: dat};
		fill_ok <= fill;
		if (fill)
			exp_dat <= dat;
		for (int w = WAYS-1; w > 0; w--) begin	// oldest way drops out
			m_tag[s][w] = m_tag[s][w-1];
			m_dat[s][w] = m_dat[s][w-1];
			m_vld[s][w] = m_vld[s][w-1];
		end
		m_tag[s][0] = adr[31:10];
		m_dat[s][0] = dat;
		m_vld[s][0] = 1'b1;
		@(posedge wclk);
		ld_req.valid <= 1'b0;
		repeat (3) @(posedge wclk);		// load spacing
	endtask

	task automatic read_line(input addr_t adr, input logic decoy);
		int   w;
		tid_t tid;
		w   = find_way(adr);
		tid = tid_t'(next_rand());
		@(posedge wclk);
		rd_req  <= '{valid: 1'b1, adr: adr, tid: tid};
		exp_hit <= (w >= 0);
		exp_adr <= adr;
		exp_tid <= tid;
		fill_ok <= 1'b0;
		rd_seq  <= rd_seq + 1;
		if (w >= 0)
			exp_dat <= m_dat[adr[9:4]][w];
		@(posedge wclk);
		rd_req.valid <= 1'b0;
		if (w < 0) begin
			@(negedge wclk);
			while (!miss.valid)
				@(negedge wclk);
			if (decoy) begin
				// another line first, the port must stay quiet
				load_line(new_adr(int'(adr[9:4])), rand_line(), 1'b0);
				repeat (8) @(posedge wclk);
			end
			load_line(adr, rand_line(), 1'b1);
		end
		@(negedge wclk);
		while (!rd_resp.ack)
			@(negedge wclk);
	endtask

	task automatic write_line(input wr_op_e op, input addr_t adr, input byte_sel_t sel,
			input line_data_t dat);
		int s;
		int w;
		s = adr[9:4];
		w = find_way(adr);
		@(posedge wclk);
		wr_req <= '{valid: 1'b1, op: op, adr: adr, sel: sel, dat: dat};
		if (w >= 0 && op == WR_STORE) begin
			for (int b = 0; b < LINE_BYTES; b++)
				if (sel[b])
					m_dat[s][w][b*8 +: 8] = dat[b*8 +: 8];
		end
		else if (w >= 0)
			m_vld[s][w] = 1'b0;
		@(posedge wclk);
		wr_req.valid <= 1'b0;
		@(negedge wclk);
		while (!wr_ack)
			@(negedge wclk);
	endtask

	// ==================================================
	// test sequence
	// ==================================================
	initial begin
		addr_t       a, b, c;
		addr_t       l [5];
		logic [31:0] r;
		int          s, w;
		rng = 32'd98601;
		rst1 = 1'b1;
		rd_req = '0;
		ld_req = '0;
		wr_req = '0;
		exp_hit = 1'b0;
		fill_ok = 1'b0;
		exp_adr = '0;
		exp_tid = '0;
		exp_dat = '0;
		rd_seq = 0;
		miss_seq = 0;
		errors = 0;
		n_rd_ack = 0;
		n_miss = 0;
		n_wr_ack = 0;
		for (int i = 0; i < SETS; i++)
			for (int j = 0; j < WAYS; j++) begin
				m_tag[i][j] = '0;
				m_dat[i][j] = '0;
				m_vld[i][j] = 1'b0;
			end
		repeat (RST_CYC) @(posedge wclk);
		rst1 <= 1'b0;

		a = new_adr(5);
		read_line(a, 1'b1);		// cold miss, decoy load, then fill
		b = new_adr(5);
		load_line(b, rand_line(), 1'b0);
		read_line(a, 1'b0);
		read_line(b, 1'b0);
		write_line(WR_STORE, a, byte_sel_t'(next_rand()), rand_line());
		read_line(a, 1'b0);
		c = new_adr(5);
		write_line(WR_STORE, c, byte_sel_t'(next_rand()), rand_line());	// not resident
		read_line(a, 1'b0);
		read_line(b, 1'b0);

		// five lines into one set, l[0] gets evicted
		for (int i = 0; i < 5; i++) begin
			l[i] = new_adr(17);
			load_line(l[i], rand_line(), 1'b0);
		end
		for (int i = 4; i > 0; i--)
			read_line(l[i], 1'b0);
		read_line(l[0], 1'b0);

		write_line(WR_INVAL, l[3], '0, '0);
		read_line(l[4], 1'b0);
		read_line(l[2], 1'b0);
		read_line(l[0], 1'b0);
		read_line(l[3], 1'b0);

		// random mix over a few sets
		for (int i = 0; i < 16; i++) begin
			r = next_rand();
			s = sets_used[r % 3];
			w = r[5:4];
			a = {m_tag[s][w], index_t'(s), r[3:0]};
			case (r[9:8])
			2'd0: read_line(a, 1'b0);
			2'd1: write_line(WR_STORE, a, byte_sel_t'(next_rand()), rand_line());
			2'd2: load_line(new_adr(s), rand_line(), 1'b0);
			default: write_line(WR_INVAL, a, '0, '0);
			endcase
		end

		repeat (4) @(posedge wclk);
		$display("summary: %0d errors, %0d read acks, %0d misses, %0d write acks",
			errors, n_rd_ack, n_miss, n_wr_ack);
		if (errors == 0)
			$display("Test passed");
		else
			$display("Test failed");
		$finish;
	end

	// watchdog
	initial begin
		#((N_OPS * 20 + RST_CYC) * CLK_NS);
		$display("timeout: the run did not finish within %0d cycles", N_OPS * 20 + RST_CYC);
		$display("Test failed");
		$finish;
	end

endmodule

`default_nettype wire

// File: mpmc_cache.f
logic/cache_pkg.sv
logic/set_ram.sv
logic/valid_bits.sv
logic/tag_match.sv
logic/read_port.sv
logic/line_update.sv
logic/mpmc_cache.sv
verification/mpmc_cache_tb.sv
